/* list.f */
source/centipede_io_pkg.sv
source/axil_bus_slave.sv
source/io_bus_decode.sv
source/trakball_counter.sv
source/player_io.sv
source/earom_store.sv
source/centipede_io_top.sv
sim/tb_centipede_io.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run the testbench, result taken from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_centipede_io \
	-f list.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/Vtb_centipede_io > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* sim/tb_centipede_io.sv */
//============================================================
// read expectations come from the model at the read handshake
// trakball pulses hold each level six cycles for the synchronizer
//============================================================
`timescale 1ns/1ps

module tb_centipede_io;

	localparam int TIMEOUT = 40;

	logic s_6mhz;
	logic reset;
	logic [13:0] awaddr;
	logic awvalid;
	logic awready;
	logic [7:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [13:0] araddr;
	logic arvalid;
	logic arready;
	logic [7:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [9:0] playerinput;
	logic [7:0] trakball;
	logic [7:0] joystick;
	logic [7:0] sw1;
	logic [7:0] sw2;
	logic vblank;
	logic flip;
	logic [3:0] led;
	logic [2:0] coin_ctr;

	// model state
	logic [7:0] m_latch;
	logic [3:0] m_hcnt;
	logic [3:0] m_vcnt;
	logic m_hdir;
	logic m_vdir;
	logic [5:0] m_ea_addr;
	logic [7:0] m_ea_data;
	logic m_cs;
	logic m_erase;
	logic m_wr;
	logic [7:0] m_ea_out;
	logic [7:0] m_mem [64];

	logic [31:0] lfsr;
	logic [31:0] rnd;
	logic [7:0] exp_q [$];
	logic [13:0] addr_q [$];
	logic [7:0] exp_data;
	logic [13:0] exp_addr;
	logic [5:0] ea_list [6];
	logic [7:0] data_v;
	int hold;
	int error_count;
	int check_count;
	event abort_ev;

	centipede_io_top centipede_io_top_i (
		.s_6mhz        (s_6mhz),
		.reset         (reset),
		.s_awaddr_i    (awaddr),
		.s_awvalid_i   (awvalid),
		.s_awready_o   (awready),
		.s_wdata_i     (wdata),
		.s_wvalid_i    (wvalid),
		.s_wready_o    (wready),
		.s_bresp_o     (bresp),
		.s_bvalid_o    (bvalid),
		.s_bready_i    (bready),
		.s_araddr_i    (araddr),
		.s_arvalid_i   (arvalid),
		.s_arready_o   (arready),
		.s_rdata_o     (rdata),
		.s_rresp_o     (rresp),
		.s_rvalid_o    (rvalid),
		.s_rready_i    (rready),
		.playerinput_i (playerinput),
		.trakball_i    (trakball),
		.joystick_i    (joystick),
		.sw1_i         (sw1),
		.sw2_i         (sw2),
		.vblank_i      (vblank),
		.flip_o        (flip),
		.led_o         (led),
		.coin_ctr_o    (coin_ctr)
	);

	always #50 s_6mhz = ~s_6mhz;

	// 32-bit fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected read data from model state
	function automatic logic [7:0] ref_read(input logic [13:0] addr);
		logic [3:0] region;
		logic [7:0] v;
		region = addr[13:10];
		v = 8'h00;
		if (region == centipede_io_pkg::REGION_SWITCH)
			v = addr[0] ? sw2 : sw1;
		else if (region == centipede_io_pkg::REGION_PLAYER)
		begin
			case (addr[1:0])
				2'd0: v = {m_hdir, vblank, playerinput[6], playerinput[5], m_hcnt};
				// coin r c l, slam, fire2, fire1, start2, start1
				2'd1: v = {playerinput[9], playerinput[8], playerinput[7], playerinput[4],
					playerinput[1], playerinput[0], playerinput[3], playerinput[2]};
				2'd2: v = {m_vdir, 3'b000, m_vcnt};
				default: v = joystick;
			endcase
		end
		else if (region == centipede_io_pkg::REGION_EAROM && addr[9] && addr[8:7] == 2'b10)
			v = m_ea_out;
		return v;
	endfunction

	// model side of a completed write
	task automatic model_write(input logic [13:0] addr, input logic [7:0] data);
		logic [3:0] region;
		region = addr[13:10];
		if (region == centipede_io_pkg::REGION_OUTLATCH)
			m_latch[addr[2:0]] = data[7];
		if (region == centipede_io_pkg::REGION_STEERCLR)
		begin
			m_hcnt = 4'd0;
			m_vcnt = 4'd0;
		end
		if (region == centipede_io_pkg::REGION_EAROM && addr[9] && addr[8:7] == 2'b00)
		begin
			m_ea_addr = addr[5:0];
			m_ea_data = data;
		end
		if (region == centipede_io_pkg::REGION_EAROM && addr[9] && addr[8:7] == 2'b01)
		begin
			m_cs = data[3];
			m_erase = data[2];
			m_wr = data[1];
		end
		// store follows the latches every cycle
		if (m_cs && m_wr)
			m_mem[m_ea_addr] = m_erase ? 8'h00 : m_ea_data;
		if (m_cs && !m_wr)
			m_ea_out = m_mem[m_ea_addr];
	endtask

	task automatic next_drive_point();
		@(posedge s_6mhz);
		#1;
	endtask

	task automatic stop_on_timeout(input string what);
		error_count++;
		$display("timeout while waiting for %s at %0t", what, $time);
		-> abort_ev;
		forever @(posedge s_6mhz);
	endtask

	// hold > 0 keeps bready low that many cycles
	task automatic axi_write(input logic [13:0] addr, input logic [7:0] data, input int hold_n);
		int cnt;
		next_drive_point();
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold_n == 0);
		cnt = 0;
		@(negedge s_6mhz);
		while (!(awready && wready))
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("awready and wready");
			@(negedge s_6mhz);
		end
		next_drive_point();
		awvalid = 1'b0;
		wvalid = 1'b0;
		model_write(addr, data);
		cnt = 0;
		@(negedge s_6mhz);
		while (!bvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("bvalid");
			@(negedge s_6mhz);
		end
		// second write offered while the response waits
		for (int i = 0; i < hold_n; i++)
		begin
			next_drive_point();
			awvalid = 1'b1;
			wvalid = 1'b1;
			@(negedge s_6mhz);
			check_count++;
			assert (bvalid && bresp == 2'b00 && !awready && !wready)
			else
			begin
				error_count++;
				$display("error at %0t: write response or ready wrong under back-pressure",
					$time);
			end
		end
		if (hold_n > 0)
		begin
			next_drive_point();
			awvalid = 1'b0;
			wvalid = 1'b0;
			bready = 1'b1;
		end
		cnt = 0;
		@(negedge s_6mhz);
		while (bvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("bvalid to fall");
			@(negedge s_6mhz);
		end
	endtask

	// hold > 0 keeps rready low that many cycles
	task automatic axi_read(input logic [13:0] addr, input int hold_n);
		int cnt;
		logic [7:0] first;
		next_drive_point();
		araddr = addr;
		arvalid = 1'b1;
		rready = (hold_n == 0);
		cnt = 0;
		@(negedge s_6mhz);
		while (!arready)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("arready");
			@(negedge s_6mhz);
		end
		exp_q.push_back(ref_read(addr));
		addr_q.push_back(addr);
		next_drive_point();
		arvalid = 1'b0;
		cnt = 0;
		@(negedge s_6mhz);
		while (!rvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("rvalid");
			@(negedge s_6mhz);
		end
		first = rdata;
		for (int i = 0; i < hold_n; i++)
		begin
			next_drive_point();
			arvalid = 1'b1;
			@(negedge s_6mhz);
			check_count++;
			assert (rvalid && rdata == first && !arready)
			else
			begin
				error_count++;
				$display("error at %0t: read response changed under back-pressure", $time);
			end
		end
		if (hold_n > 0)
		begin
			next_drive_point();
			arvalid = 1'b0;
			rready = 1'b1;
		end
		cnt = 0;
		@(negedge s_6mhz);
		while (rvalid)
		begin
			cnt++;
			if (cnt > TIMEOUT)
				stop_on_timeout("rvalid to fall");
			@(negedge s_6mhz);
		end
	endtask

	task automatic check_outputs();
		check_count++;
		assert ({flip, led, coin_ctr} == m_latch)
		else
		begin
			error_count++;
			$display("error at %0t: latch outputs %b, expected %b", $time,
				{flip, led, coin_ctr}, m_latch);
		end
	endtask

	// dir is set two cycles ahead of the ck rise
	task automatic pulse_trakball(input int ck_bit, input int dir_bit, input logic dir_val);
		int h_bit;
		int v_bit;
		h_bit = m_latch[7] ? 5 : 4;
		v_bit = m_latch[7] ? 1 : 0;
		next_drive_point();
		trakball[dir_bit] = dir_val;
		repeat (2) next_drive_point();
		trakball[ck_bit] = 1'b1;
		repeat (6) next_drive_point();
		trakball[ck_bit] = 1'b0;
		repeat (6) next_drive_point();
		if (ck_bit == h_bit)
		begin
			m_hcnt = m_hdir ? m_hcnt + 4'd1 : m_hcnt - 4'd1;
			m_hdir = dir_val;
		end
		else if (ck_bit == v_bit)
		begin
			m_vcnt = m_vdir ? m_vcnt + 4'd1 : m_vcnt - 4'd1;
			m_vdir = dir_val;
		end
	endtask

	// compares every accepted response
	always @(negedge s_6mhz)
	begin
		if (!reset && rvalid && rready)
		begin
			if (exp_q.size() == 0)
			begin
				error_count++;
				$display("read response arrived with no read request at %0t", $time);
			end
			else
			begin
				exp_data = exp_q.pop_front();
				exp_addr = addr_q.pop_front();
				check_count++;
				assert (rdata == exp_data && rresp == 2'b00)
				else
				begin
					error_count++;
					$display("error at %0t: read %h gave %h resp %b, expected %h", $time,
						exp_addr, rdata, rresp, exp_data);
				end
			end
		end
		if (!reset && bvalid && bready)
		begin
			check_count++;
			assert (bresp == 2'b00)
			else
			begin
				error_count++;
				$display("error at %0t: write response %b", $time, bresp);
			end
		end
	end

	initial
	begin
		@(abort_ev);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		s_6mhz = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		playerinput = '0;
		trakball = '0;
		joystick = '0;
		sw1 = '0;
		sw2 = '0;
		vblank = 1'b0;
		lfsr = 32'h02e3d8ec;
		m_latch = '0;
		m_hcnt = '0;
		m_vcnt = '0;
		m_hdir = 1'b0;
		m_vdir = 1'b0;
		m_ea_addr = '0;
		m_ea_data = '0;
		m_cs = 1'b0;
		m_erase = 1'b0;
		m_wr = 1'b0;
		m_ea_out = '0;
		for (int i = 0; i < 64; i++)
			m_mem[i] = 8'h00;
		error_count = 0;
		check_count = 0;
		repeat (3) @(posedge s_6mhz);
		#1;
		reset = 1'b0;

		// input ports with random levels
		for (int n = 0; n < 6; n++)
		begin
			next_drive_point();
			rnd = take_bits(10);
			playerinput = rnd[9:0];
			rnd = take_bits(25);
			joystick = rnd[7:0];
			sw1 = rnd[15:8];
			sw2 = rnd[23:16];
			vblank = rnd[24];
			axi_read(14'h0800, 0);
			axi_read(14'h0801, 0);
			for (int a = 0; a < 4; a++)
				axi_read(14'h0C00 + 14'(a), 0);
		end
		// unmapped or write-only addresses
		axi_read(14'h0000, 0);
		axi_read(14'h1400, 0);
		axi_read(14'h1600, 0);
		axi_read(14'h1C00, 0);
		axi_read(14'h2400, 0);
		axi_read(14'h3FFF, 0);

		// addressable output latch
		for (int a = 0; a < 8; a++)
		begin
			rnd = take_bits(8);
			axi_write({11'h380, 3'(a)}, rnd[7:0], 0);
			check_outputs();
		end
		axi_write(14'h1C07, 8'h00, 0);
		check_outputs();

		// player-two trakball wrapping past 4 bits
		for (int n = 0; n < 18; n++)
		begin
			pulse_trakball(4, 6, 1'b1);
			axi_read(14'h0C00, 0);
		end
		for (int n = 0; n < 5; n++)
		begin
			pulse_trakball(0, 2, 1'b0);
			axi_read(14'h0C02, 0);
		end
		axi_write(14'h2400, 8'h00, 0);
		axi_read(14'h0C00, 0);
		axi_read(14'h0C02, 0);

		// flip moves the counters to player one
		axi_write(14'h1C07, 8'h80, 0);
		check_outputs();
		for (int n = 0; n < 3; n++)
		begin
			pulse_trakball(4, 6, 1'b1);
			pulse_trakball(0, 2, 1'b1);
			axi_read(14'h0C00, 0);
			axi_read(14'h0C02, 0);
			pulse_trakball(5, 7, 1'b1);
			pulse_trakball(1, 3, 1'b0);
			axi_read(14'h0C00, 0);
			axi_read(14'h0C02, 0);
		end

		// earom write then read back
		for (int n = 0; n < 6; n++)
		begin
			rnd = take_bits(14);
			ea_list[n] = rnd[5:0];
			axi_write({8'h58, rnd[5:0]}, rnd[13:6], 0);
			axi_write(14'h1680, 8'h0A, 0);
			axi_write(14'h1680, 8'h00, 0);
		end
		for (int n = 0; n < 6; n++)
		begin
			axi_write({8'h58, ea_list[n]}, 8'h00, 0);
			axi_write(14'h1680, 8'h08, 0);
			axi_read(14'h1700, 0);
			axi_write(14'h1680, 8'h00, 0);
		end
		// erase one byte
		axi_write({8'h58, ea_list[0]}, 8'h5A, 0);
		axi_write(14'h1680, 8'h0E, 0);
		axi_write(14'h1680, 8'h00, 0);
		axi_write(14'h1680, 8'h08, 0);
		axi_read(14'h1700, 0);
		axi_write(14'h1680, 8'h00, 0);

		// responses held by bready and rready
		for (int n = 0; n < 4; n++)
		begin
			rnd = take_bits(3);
			hold = int'(rnd[2:0]) + 1;
			rnd = take_bits(8);
			data_v = rnd[7:0];
			axi_write({11'h380, 3'(n + 1)}, data_v, hold);
			check_outputs();
			rnd = take_bits(3);
			hold = int'(rnd[2:0]) + 1;
			axi_read(14'h0C03, hold);
			axi_read(14'h0801, hold);
		end

		repeat (4) next_drive_point();
		check_count++;
		assert (exp_q.size() == 0)
		else
		begin
			error_count++;
			$display("some reads never got a response");
		end
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* source/centipede_io_top.sv */
//============================================================
// axi byte address is the game cpu address, 8-bit data only
//============================================================
`timescale 1ns/1ps

module centipede_io_top (
	input  logic                                  s_6mhz,
	input  logic                                  reset,
	input  logic [centipede_io_pkg::ADDR_W-1:0]   s_awaddr_i,
	input  logic                                  s_awvalid_i,
	output logic                                  s_awready_o,
	input  logic [centipede_io_pkg::DATA_W-1:0]   s_wdata_i,
	input  logic                                  s_wvalid_i,
	output logic                                  s_wready_o,
	output logic [1:0]                            s_bresp_o,
	output logic                                  s_bvalid_o,
	input  logic                                  s_bready_i,
	input  logic [centipede_io_pkg::ADDR_W-1:0]   s_araddr_i,
	input  logic                                  s_arvalid_i,
	output logic                                  s_arready_o,
	output logic [centipede_io_pkg::DATA_W-1:0]   s_rdata_o,
	output logic [1:0]                            s_rresp_o,
	output logic                                  s_rvalid_o,
	input  logic                                  s_rready_i,
	input  logic [9:0]                            playerinput_i,
	input  logic [7:0]                            trakball_i,
	input  logic [7:0]                            joystick_i,
	input  logic [7:0]                            sw1_i,
	input  logic [7:0]                            sw2_i,
	input  logic                                  vblank_i,
	output logic                                  flip_o,
	output logic [3:0]                            led_o,
	output logic [2:0]                            coin_ctr_o
);

	logic [centipede_io_pkg::ADDR_W-1:0] bus_addr;
	logic [centipede_io_pkg::DATA_W-1:0] bus_wdata;
	logic [centipede_io_pkg::DATA_W-1:0] bus_rdata;
	logic bus_wr;
	logic bus_rd;
	logic out_wr;
	logic steer_clr;
	logic ea_addr_wr;
	logic ea_ctrl_wr;
	logic player_sel;
	logic [centipede_io_pkg::DATA_W-1:0] player_rdata;
	logic [centipede_io_pkg::DATA_W-1:0] ea_rdata;

	axil_bus_slave u_axil (
		.s_6mhz      (s_6mhz),
		.reset       (reset),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.bus_addr_o  (bus_addr),
		.bus_wdata_o (bus_wdata),
		.bus_wr_o    (bus_wr),
		.bus_rd_o    (bus_rd),
		.bus_rdata_i (bus_rdata)
	);

	io_bus_decode u_decode (
		.bus_addr_i     (bus_addr),
		.bus_wr_i       (bus_wr),
		.bus_rd_i       (bus_rd),
		.bus_rdata_o    (bus_rdata),
		.out_wr_o       (out_wr),
		.steer_clr_o    (steer_clr),
		.ea_addr_wr_o   (ea_addr_wr),
		.ea_ctrl_wr_o   (ea_ctrl_wr),
		.player_sel_o   (player_sel),
		.player_rdata_i (player_rdata),
		.ea_rdata_i     (ea_rdata)
	);

	player_io u_player (
		.s_6mhz         (s_6mhz),
		.reset          (reset),
		.out_wr_i       (out_wr),
		.steer_clr_i    (steer_clr),
		.bus_addr_i     (bus_addr),
		.bus_wdata_i    (bus_wdata),
		.player_sel_i   (player_sel),
		.player_rdata_o (player_rdata),
		.playerinput_i  (playerinput_i),
		.trakball_i     (trakball_i),
		.joystick_i     (joystick_i),
		.sw1_i          (sw1_i),
		.sw2_i          (sw2_i),
		.vblank_i       (vblank_i),
		.flip_o         (flip_o),
		.led_o          (led_o),
		.coin_ctr_o     (coin_ctr_o)
	);

	// earom only sees the low address bits
	earom_store u_earom (
		.s_6mhz       (s_6mhz),
		.reset        (reset),
		.ea_addr_wr_i (ea_addr_wr),
		.ea_ctrl_wr_i (ea_ctrl_wr),
		.bus_addr_i   (bus_addr[centipede_io_pkg::EA_ADDR_W-1:0]),
		.bus_wdata_i  (bus_wdata),
		.ea_rdata_o   (ea_rdata)
	);

endmodule

/* source/earom_store.sv */
//============================================================
// store is written every cycle while cs and write are latched
// data bit 0 of the control (earom clock) has no effect here
//============================================================
`timescale 1ns/1ps

module earom_store (
	input  logic                                    s_6mhz,
	input  logic                                    reset,
	input  logic                                    ea_addr_wr_i,
	input  logic                                    ea_ctrl_wr_i,
	input  logic [centipede_io_pkg::EA_ADDR_W-1:0]  bus_addr_i,
	input  logic [centipede_io_pkg::DATA_W-1:0]     bus_wdata_i,
	output logic [centipede_io_pkg::DATA_W-1:0]     ea_rdata_o
);

	logic [centipede_io_pkg::DATA_W-1:0] mem [centipede_io_pkg::EA_DEPTH];
	logic [centipede_io_pkg::EA_ADDR_W-1:0] ea_addr;
	logic [centipede_io_pkg::DATA_W-1:0] ea_data;
	// cs from data bit 3
	logic ea_cs;
	// erase from data bit 2
	logic ea_erase;
	// inverse of data bit 1, low means write
	logic ea_wr_n;

	// address/data and control latches
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			ea_addr <= '0;
			ea_data <= '0;
			ea_cs <= 1'b0;
			ea_erase <= 1'b0;
			ea_wr_n <= 1'b1;
		end
		else
		begin
			if (ea_addr_wr_i)
			begin
				ea_addr <= bus_addr_i;
				ea_data <= bus_wdata_i;
			end
			if (ea_ctrl_wr_i)
			begin
				ea_cs <= bus_wdata_i[3];
				ea_erase <= bus_wdata_i[2];
				ea_wr_n <= ~bus_wdata_i[1];
			end
		end
	end

	// write or erase
	always_ff @(posedge s_6mhz)
	begin
		if (ea_cs & ~ea_wr_n)
			mem[ea_addr] <= ea_erase ? '0 : ea_data;
	end

	// read mode refreshes the output register every cycle
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			ea_rdata_o <= '0;
		else if (ea_cs & ea_wr_n)
			ea_rdata_o <= mem[ea_addr];
	end

endmodule

/* source/player_io.sv */
//============================================================
// flip selects the player-one trakball bits, else player two
// read data is zero unless player_sel_i is set
//============================================================
`timescale 1ns/1ps

module player_io (
	input  logic                                  s_6mhz,
	input  logic                                  reset,
	input  logic                                  out_wr_i,
	input  logic                                  steer_clr_i,
	input  logic [centipede_io_pkg::ADDR_W-1:0]   bus_addr_i,
	input  logic [centipede_io_pkg::DATA_W-1:0]   bus_wdata_i,
	input  logic                                  player_sel_i,
	output logic [centipede_io_pkg::DATA_W-1:0]   player_rdata_o,
	input  logic [9:0]                            playerinput_i,
	input  logic [7:0]                            trakball_i,
	input  logic [7:0]                            joystick_i,
	input  logic [7:0]                            sw1_i,
	input  logic [7:0]                            sw2_i,
	input  logic                                  vblank_i,
	output logic                                  flip_o,
	output logic [3:0]                            led_o,
	output logic [2:0]                            coin_ctr_o
);

	logic [7:0] out_latch;
	logic [centipede_io_pkg::REGION_W-1:0] region;
	logic h_ck;
	logic h_dir_in;
	logic v_ck;
	logic v_dir_in;
	logic [centipede_io_pkg::TB_CTR_W-1:0] h_count;
	logic [centipede_io_pkg::TB_CTR_W-1:0] v_count;
	logic h_dir;
	logic v_dir;

	// addressable latch, bit 7 of the data goes to latch bit a2..a0
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			out_latch <= '0;
		else if (out_wr_i)
			out_latch[bus_addr_i[2:0]] <= bus_wdata_i[7];
	end

	// 7 flip, 6..3 leds 4..1, 2..0 coin counters r c l
	assign flip_o = out_latch[7];
	assign led_o = out_latch[6:3];
	assign coin_ctr_o = out_latch[2:0];

	// trakball_i: 7/6 h dir, 5/4 h ck, 3/2 v dir, 1/0 v ck (p1/p2)
	assign h_dir_in = flip_o ? trakball_i[7] : trakball_i[6];
	assign h_ck = flip_o ? trakball_i[5] : trakball_i[4];
	assign v_dir_in = flip_o ? trakball_i[3] : trakball_i[2];
	assign v_ck = flip_o ? trakball_i[1] : trakball_i[0];

	trakball_counter u_tb_horiz (
		.s_6mhz  (s_6mhz),
		.reset   (reset),
		.ck_i    (h_ck),
		.dir_i   (h_dir_in),
		.clr_i   (steer_clr_i),
		.count_o (h_count),
		.dir_o   (h_dir)
	);

	trakball_counter u_tb_vert (
		.s_6mhz  (s_6mhz),
		.reset   (reset),
		.ck_i    (v_ck),
		.dir_i   (v_dir_in),
		.clr_i   (steer_clr_i),
		.count_o (v_count),
		.dir_o   (v_dir)
	);

	assign region = bus_addr_i[centipede_io_pkg::ADDR_W-1 -: centipede_io_pkg::REGION_W];

	// read formatting
	always_comb
	begin
		player_rdata_o = '0;
		if (player_sel_i)
		begin
			if (region == centipede_io_pkg::REGION_SWITCH)
				player_rdata_o = bus_addr_i[0] ? sw2_i : sw1_i;
			else
			begin
				case (bus_addr_i[1:0])
					// h dir, vblank, self test, cocktail, h count
					2'd0: player_rdata_o = {h_dir, vblank_i, playerinput_i[6:5], h_count};
					// coins r c l, slam, fire2, fire1, start2, start1
					2'd1: player_rdata_o = {playerinput_i[9:7], playerinput_i[4],
						playerinput_i[1:0], playerinput_i[3:2]};
					2'd2: player_rdata_o = {v_dir, 3'b000, v_count};
					default: player_rdata_o = joystick_i;
				endcase
			end
		end
	end

endmodule

/* source/trakball_counter.sv */
//============================================================
// ck and dir are asynchronous, counts 2 to 3 cycles after ck
//============================================================
`timescale 1ns/1ps

module trakball_counter (
	input  logic                                  s_6mhz,
	input  logic                                  reset,
	input  logic                                  ck_i,
	input  logic                                  dir_i,
	input  logic                                  clr_i,
	output logic [centipede_io_pkg::TB_CTR_W-1:0] count_o,
	output logic                                  dir_o
);

	localparam int LAST = centipede_io_pkg::SYNC_STAGES - 1;

	logic [LAST:0] ck_sync;
	logic [LAST:0] dir_sync;
	logic ck_last;
	logic ck_rise;

	assign ck_rise = ck_sync[LAST] & ~ck_last;

	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			ck_sync <= '0;
			dir_sync <= '0;
			ck_last <= 1'b0;
			count_o <= '0;
			dir_o <= 1'b0;
		end
		else
		begin
			ck_sync <= {ck_sync[LAST-1:0], ck_i};
			dir_sync <= {dir_sync[LAST-1:0], dir_i};
			ck_last <= ck_sync[LAST];
			// direction from the previous ck edge decides this step
			if (clr_i)
				count_o <= '0;
			else if (ck_rise)
				count_o <= dir_o ? count_o + 1'b1 : count_o - 1'b1;
			if (ck_rise)
				dir_o <= dir_sync[LAST];
		end
	end

endmodule

/* source/io_bus_decode.sv */
//============================================================
// region decode on address bits 13 to 10
// unmapped reads return zero
//============================================================
`timescale 1ns/1ps

module io_bus_decode (
	input  logic [centipede_io_pkg::ADDR_W-1:0]   bus_addr_i,
	input  logic                                  bus_wr_i,
	input  logic                                  bus_rd_i,
	output logic [centipede_io_pkg::DATA_W-1:0]   bus_rdata_o,
	output logic                                  out_wr_o,
	output logic                                  steer_clr_o,
	output logic                                  ea_addr_wr_o,
	output logic                                  ea_ctrl_wr_o,
	output logic                                  player_sel_o,
	input  logic [centipede_io_pkg::DATA_W-1:0]   player_rdata_i,
	input  logic [centipede_io_pkg::DATA_W-1:0]   ea_rdata_i
);

	logic [centipede_io_pkg::REGION_W-1:0] region;
	logic [1:0] ea_sel;
	logic ea_hit;
	logic ea_read;

	assign region = bus_addr_i[centipede_io_pkg::ADDR_W-1 -: centipede_io_pkg::REGION_W];

	// earom lives in the upper half of its region
	assign ea_hit = (region == centipede_io_pkg::REGION_EAROM) & bus_addr_i[9];
	assign ea_sel = bus_addr_i[8:7];
	assign ea_read = ea_hit & (ea_sel == centipede_io_pkg::EA_SEL_READ);

	// write strobes, one cycle like bus_wr_i
	assign out_wr_o = bus_wr_i & (region == centipede_io_pkg::REGION_OUTLATCH);
	assign steer_clr_o = bus_wr_i & (region == centipede_io_pkg::REGION_STEERCLR);
	assign ea_addr_wr_o = bus_wr_i & ea_hit & (ea_sel == centipede_io_pkg::EA_SEL_ADDR);
	assign ea_ctrl_wr_o = bus_wr_i & ea_hit & (ea_sel == centipede_io_pkg::EA_SEL_CTRL);

	// switch and player regions both read through player_io
	assign player_sel_o = (region == centipede_io_pkg::REGION_SWITCH) |
		(region == centipede_io_pkg::REGION_PLAYER);

	// read data back to the slave in the strobe cycle
	always_comb
	begin
		bus_rdata_o = '0;
		if (bus_rd_i)
		begin
			if (player_sel_o)
				bus_rdata_o = player_rdata_i;
			else if (ea_read)
				bus_rdata_o = ea_rdata_i;
		end
	end

endmodule

/* source/axil_bus_slave.sv */
//============================================================
// one transaction at a time, read wins over a same-edge write
// no write strobes or protection, responses always OKAY
//============================================================
`timescale 1ns/1ps

module axil_bus_slave (
	input  logic                                  s_6mhz,
	input  logic                                  reset,
	input  logic [centipede_io_pkg::ADDR_W-1:0]   s_awaddr_i,
	input  logic                                  s_awvalid_i,
	output logic                                  s_awready_o,
	input  logic [centipede_io_pkg::DATA_W-1:0]   s_wdata_i,
	input  logic                                  s_wvalid_i,
	output logic                                  s_wready_o,
	output logic [1:0]                            s_bresp_o,
	output logic                                  s_bvalid_o,
	input  logic                                  s_bready_i,
	input  logic [centipede_io_pkg::ADDR_W-1:0]   s_araddr_i,
	input  logic                                  s_arvalid_i,
	output logic                                  s_arready_o,
	output logic [centipede_io_pkg::DATA_W-1:0]   s_rdata_o,
	output logic [1:0]                            s_rresp_o,
	output logic                                  s_rvalid_o,
	input  logic                                  s_rready_i,
	output logic [centipede_io_pkg::ADDR_W-1:0]   bus_addr_o,
	output logic [centipede_io_pkg::DATA_W-1:0]   bus_wdata_o,
	output logic                                  bus_wr_o,
	output logic                                  bus_rd_o,
	input  logic [centipede_io_pkg::DATA_W-1:0]   bus_rdata_i
);

	logic busy;
	logic wr_ready;
	logic rd_go;
	logic wr_go;

	// busy from the handshake until the response is taken
	assign busy = bus_wr_o | bus_rd_o | s_bvalid_o | s_rvalid_o;

	assign s_arready_o = ~busy;
	// write side steps back while a read address is offered
	assign wr_ready = ~busy & ~s_arvalid_i;
	assign s_awready_o = wr_ready;
	assign s_wready_o = wr_ready;

	assign rd_go = s_arvalid_i & ~busy;
	// address and data must both be there
	assign wr_go = s_awvalid_i & s_wvalid_i & wr_ready;

	assign s_bresp_o = centipede_io_pkg::RESP_OKAY;
	assign s_rresp_o = centipede_io_pkg::RESP_OKAY;

	// one-cycle bus strobes and response valids
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			bus_wr_o <= 1'b0;
			bus_rd_o <= 1'b0;
			s_bvalid_o <= 1'b0;
			s_rvalid_o <= 1'b0;
		end
		else
		begin
			bus_wr_o <= wr_go;
			bus_rd_o <= rd_go;
			// write lands with the strobe, response follows it
			if (bus_wr_o)
				s_bvalid_o <= 1'b1;
			else if (s_bready_i)
				s_bvalid_o <= 1'b0;
			// read data captured on the strobe edge
			if (bus_rd_o)
				s_rvalid_o <= 1'b1;
			else if (s_rready_i)
				s_rvalid_o <= 1'b0;
		end
	end

	// address, write data and read data
	always_ff @(posedge s_6mhz)
	begin
		if (rd_go)
			bus_addr_o <= s_araddr_i;
		else if (wr_go)
		begin
			bus_addr_o <= s_awaddr_i;
			bus_wdata_o <= s_wdata_i;
		end
		// held stable while rvalid waits on rready
		if (bus_rd_o)
			s_rdata_o <= bus_rdata_i;
	end

endmodule

/* source/centipede_io_pkg.sv */
//============================================================
// byte address is the 14-bit game cpu address
// region value is address bits 13 to 10
//============================================================
package centipede_io_pkg;

	// bus widths
	localparam int ADDR_W = 14;
	localparam int DATA_W = 8;

	// region field taken from the top address bits
	localparam int REGION_W = 4;

	// axi response code, only OKAY is ever returned
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// region values, base address in brackets
	// option switches (0x0800)
	localparam logic [REGION_W-1:0] REGION_SWITCH = 4'd2;
	// player inputs and joystick (0x0C00)
	localparam logic [REGION_W-1:0] REGION_PLAYER = 4'd3;
	// earom block (0x1400), needs address bit 9 as well
	localparam logic [REGION_W-1:0] REGION_EAROM = 4'd5;
	// addressable output latch (0x1C00)
	localparam logic [REGION_W-1:0] REGION_OUTLATCH = 4'd7;
	// trakball steering clear (0x2400)
	localparam logic [REGION_W-1:0] REGION_STEERCLR = 4'd9;

	// earom sub-select on address bits 8 to 7
	// address/data latch at 0x1600
	localparam logic [1:0] EA_SEL_ADDR = 2'b00;
	// control latch at 0x1680
	localparam logic [1:0] EA_SEL_CTRL = 2'b01;
	// read port at 0x1700
	localparam logic [1:0] EA_SEL_READ = 2'b10;

	// earom store
	localparam int EA_ADDR_W = 6;
	localparam int EA_DEPTH = 64;

	// trakball axis counter and its input synchronizer
	localparam int TB_CTR_W = 4;
	localparam int SYNC_STAGES = 2;

endpackage
